// File: Bender.yml
package:
  name: ecc_interconnect

sources:
  - source/ecc_xbar_pkg.sv
  - source/secded_encoder.sv
  - source/secded_decoder.sv
  - source/bank_request_arbiter.sv
  - source/response_router.sv
  - source/ecc_error_counters.sv
  - source/ecc_interconnect_top.sv
  - target: simulation
    files:
      - sim/bank_model.sv
      - sim/tb_ecc_interconnect.sv

// File: files.f
source/ecc_xbar_pkg.sv
source/secded_encoder.sv
source/secded_decoder.sv
source/bank_request_arbiter.sv
source/response_router.sv
source/ecc_error_counters.sv
source/ecc_interconnect_top.sv
sim/bank_model.sv
sim/tb_ecc_interconnect.sv

// File: sim/bank_model.sv
// Testbench memory banks with one-cycle read latency and bit-flip fault injection
`default_nettype none

module bank_model (
  input  logic                                                      clk_i,
  input  logic                                                      rst_ni,
  input  ecc_xbar_pkg::bank_req_t [ecc_xbar_pkg::N_BANK-1:0]        bank_req_i,
  output logic [ecc_xbar_pkg::N_BANK-1:0][ecc_xbar_pkg::CODE_W-1:0] rcode_o
);
  import ecc_xbar_pkg::*;

  logic [CODE_W-1:0]     mem [N_BANK][2**ROW_W];                  // Raw codewords per bank
  logic                  inj_valid = 1'b0;                        // Flip due at next edge
  logic [BANK_SEL_W-1:0] inj_bank;
  logic [ROW_W-1:0]      inj_row;
  logic [CODE_W-1:0]     inj_mask;                                // Bits to invert

  always @(posedge clk_i) begin : proc_store
    for (int b = 0; b < N_BANK; b++) begin
      if (bank_req_i[b].req && bank_req_i[b].we) begin
        mem[b][bank_req_i[b].row] <= bank_req_i[b].wcode;         // Full codeword write
      end
    end
    if (inj_valid) begin
      mem[inj_bank][inj_row] <= mem[inj_bank][inj_row] ^ inj_mask;
    end
  end

  always @(posedge clk_i or negedge rst_ni) begin : proc_read
    if (!rst_ni) begin
      rcode_o <= '0;                                              // All zero is a clean codeword
    end else begin
      for (int b = 0; b < N_BANK; b++) begin
        if (bank_req_i[b].req && !bank_req_i[b].we) begin
          rcode_o[b] <= mem[b][bank_req_i[b].row];                // One-cycle latency
        end
      end
    end
  end

  // Corrupts a stored word on the following rising edge
  task automatic flip_bits(input int bank, input int row, input logic [CODE_W-1:0] mask);
    inj_bank  = BANK_SEL_W'(bank);
    inj_row   = ROW_W'(row);
    inj_mask  = mask;
    inj_valid = 1'b1;
    @(posedge clk_i);
    #1;
    inj_valid = 1'b0;
  endtask

endmodule

`default_nettype wire

// File: sim/tb_ecc_interconnect.sv
// Testbench for the ECC interconnect with stimulus, reference memory and assertions
`default_nettype none

module tb_ecc_interconnect;
  import ecc_xbar_pkg::*;

  logic                          clk_i;
  logic                          rst_ni;
  core_req_t [N_INIT-1:0]        core_req;
  core_rsp_t [N_INIT-1:0]        core_rsp;
  bank_req_t [N_BANK-1:0]        bank_req;
  logic [N_BANK-1:0][CODE_W-1:0] bank_rcode;
  reg_req_t                      reg_req;
  reg_rsp_t                      reg_rsp;

  logic [DATA_W-1:0] ref_mem [2**(ADDR_W-2)];                     // Last word per word address
  logic [DATA_W-1:0] exp_data [N_INIT];                           // Expected read word per core
  logic [ADDR_W-1:0] addr_log [32];                               // Addresses written in test 1
  logic              pend_we [N_INIT];
  logic [ADDR_W-1:0] pend_addr [N_INIT];
  logic [DATA_W-1:0] pend_data [N_INIT];
  logic              expect_multi;                                // Next reads must flag r_err
  logic [CNT_W-1:0]  cnt_a;
  logic [CNT_W-1:0]  cnt_b;
  logic [CNT_W-1:0]  cnt_c;
  int                rd_pending;                                  // Reads granted, not answered
  int                err_cnt;
  int                test_cnt;
  int                test_fail;
  int                test_err0;
  int                seed;
  string             test_name;

  ecc_interconnect_top i_ecc_interconnect_top (
    .clk_i        ( clk_i      ),
    .rst_ni       ( rst_ni     ),
    .core_req_i   ( core_req   ),
    .core_rsp_o   ( core_rsp   ),
    .bank_req_o   ( bank_req   ),
    .bank_rcode_i ( bank_rcode ),
    .reg_req_i    ( reg_req    ),
    .reg_rsp_o    ( reg_rsp    )
  );

  bank_model i_bank_model (
    .clk_i      ( clk_i      ),
    .rst_ni     ( rst_ni     ),
    .bank_req_i ( bank_req   ),
    .rcode_o    ( bank_rcode )
  );

  initial begin : proc_clk
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;                                    // Period 8
  end

  task automatic flag_error(input string msg);
    $display("Error in %s: %s", test_name, msg);
    err_cnt++;
  endtask

  task automatic check_equal(input string what, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      $display("[FAIL] %s %s: expected %h, actual %h", test_name, what, exp, act);
      err_cnt++;
    end
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    test_err0 = err_cnt;
    test_cnt++;
  endtask

  task automatic end_test();
    if (err_cnt != test_err0) begin
      test_fail++;
    end
    $display("Test %0d %s: %s", test_cnt, test_name, (err_cnt == test_err0) ? "ok" : "failed");
  endtask

  // Byte address with the bank in bits 3 to 2 and the row above
  function automatic logic [ADDR_W-1:0] make_addr(input int bank, input int row);
    return ADDR_W'((row << 4) | (bank << 2));
  endfunction

  // Bank access must come from the granted core that targets this bank
  function automatic logic bank_req_ok(input int b);
    logic ok;
    logic seen;
    ok   = 1'b1;
    seen = 1'b0;
    for (int c = 0; c < N_INIT; c++) begin
      if (core_req[c].req && core_rsp[c].gnt &&
          (core_req[c].addr[3:2] == BANK_SEL_W'(b))) begin
        seen = 1'b1;
        ok   = ok && (bank_req[b].we === core_req[c].we) &&
               (bank_req[b].row === core_req[c].addr[ADDR_W-1:4]);
      end
    end
    return ok && (bank_req[b].req === seen);
  endfunction

  task automatic set_req(input int c, input logic we, input logic [ADDR_W-1:0] addr,
                         input logic [DATA_W-1:0] data);
    pend_we[c]   = we;
    pend_addr[c] = addr;
    pend_data[c] = data;
  endtask

  // Cores hold req until gnt, then drop it
  task automatic run_round(input logic [N_INIT-1:0] en, input logic same_bank,
                           input logic at_once);
    logic [N_INIT-1:0] waiting;
    logic [N_INIT-1:0] granted;
    int                cyc;
    waiting = en;
    cyc     = 0;
    for (int c = 0; c < N_INIT; c++) begin
      core_req[c] = '{req: en[c], we: pend_we[c], addr: pend_addr[c], wdata: pend_data[c]};
    end
    while ((waiting != '0) && (cyc < 16)) begin
      @(posedge clk_i);
      cyc++;
      for (int c = 0; c < N_INIT; c++) begin
        granted[c] = core_rsp[c].gnt && waiting[c];
      end
      if (same_bank) begin
        assert ($countones(granted) == 1) else flag_error("contended bank did not grant one core");
      end
      if (granted != '0) begin
        assert (cyc <= (at_once ? 1 : N_INIT)) else flag_error("core granted too late");
      end
      #1;
      for (int c = 0; c < N_INIT; c++) begin
        if (granted[c]) begin
          core_req[c].req = 1'b0;
        end
      end
      waiting &= ~granted;
    end
    if (waiting != '0) begin
      flag_error("request timed out without a grant");
    end
  endtask

  task automatic wait_reads();
    int n;
    n = 0;
    while ((rd_pending != 0) && (n < 10)) begin
      @(posedge clk_i);
      #1;
      n++;
    end
    if (rd_pending != 0) begin
      flag_error("read response timed out");
    end
  endtask

  task automatic reg_access(input logic we, input ecc_reg_e op, output logic [CNT_W-1:0] rdata);
    int   n;
    logic got;
    n       = 0;
    got     = 1'b0;
    rdata   = '0;
    reg_req = '{valid: 1'b1, we: we, op: op};                     // One-cycle strobe
    @(posedge clk_i);
    #1;
    reg_req.valid = 1'b0;
    while (!got && (n < 8)) begin
      @(posedge clk_i);
      if (reg_rsp.valid) begin
        got   = 1'b1;
        rdata = reg_rsp.rdata;
      end
      #1;
      n++;
    end
    if (!got) begin
      flag_error("register response timed out");
    end
  endtask

  // Tracks writes and checks every read response against the reference memory
  always @(posedge clk_i) begin : proc_monitor
    if (rst_ni) begin
      for (int b = 0; b < N_BANK; b++) begin
        assert (bank_req_ok(b))
          else flag_error("bank request does not match the granted core");
      end
      for (int c = 0; c < N_INIT; c++) begin
        if (core_rsp[c].r_valid) begin
          check_equal("r_err", 32'(expect_multi), 32'(core_rsp[c].r_err));
          if (!expect_multi) begin
            check_equal("r_data", exp_data[c], core_rsp[c].r_data);
          end
          rd_pending--;
        end
        if (core_req[c].req && core_rsp[c].gnt) begin
          if (core_req[c].we) begin
            ref_mem[core_req[c].addr[ADDR_W-1:2]] = core_req[c].wdata;
          end else begin
            exp_data[c] = ref_mem[core_req[c].addr[ADDR_W-1:2]];
            rd_pending++;
          end
        end
      end
    end
  end

  for (genvar c = 0; c < N_INIT; c++) begin : gen_rsp_chk
    a_rvalid_after_gnt: assert property (@(posedge clk_i) disable iff (!rst_ni)
      (core_req[c].req && !core_req[c].we && core_rsp[c].gnt) |=> core_rsp[c].r_valid)
      else flag_error("read grant not followed by r_valid one cycle later");
    a_rvalid_needs_gnt: assert property (@(posedge clk_i) disable iff (!rst_ni)
      core_rsp[c].r_valid |-> $past(core_req[c].req && !core_req[c].we && core_rsp[c].gnt))
      else flag_error("r_valid without a read grant one cycle before");
    a_gnt_needs_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
      core_rsp[c].gnt |-> core_req[c].req)
      else flag_error("gnt without a request");
  end

  a_reg_rsp: assert property (@(posedge clk_i) disable iff (!rst_ni)
    reg_req.valid |=> reg_rsp.valid)
    else flag_error("register response missing one cycle after the strobe");

  initial begin : proc_main
    seed         = 56085;
    err_cnt      = 0;
    test_cnt     = 0;
    test_fail    = 0;
    rd_pending   = 0;
    expect_multi = 1'b0;
    test_name    = "reset";
    core_req     = '0;
    reg_req      = '0;
    rst_ni       = 1'b0;
    repeat (10) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;

    begin_test("random write and read");
    for (int r = 0; r < 8; r++) begin
      for (int c = 0; c < N_INIT; c++) begin
        addr_log[r*N_INIT+c] = ADDR_W'($random(seed) & 32'h3fc);  // Rows below 64
        set_req(c, 1'b1, addr_log[r*N_INIT+c], $random(seed));
      end
      run_round(4'hf, 1'b0, 1'b0);
    end
    for (int r = 0; r < 8; r++) begin
      for (int c = 0; c < N_INIT; c++) begin
        set_req(c, 1'b0, addr_log[$unsigned($random(seed)) % 32], '0);
      end
      run_round(4'hf, 1'b0, 1'b0);
    end
    wait_reads();
    end_test();

    begin_test("same bank contention");
    for (int w = 1; w >= 0; w--) begin
      for (int c = 0; c < N_INIT; c++) begin
        set_req(c, w[0], make_addr(1, 64 + c), $random(seed));
      end
      run_round(4'hf, 1'b1, 1'b0);
    end
    wait_reads();
    end_test();

    begin_test("parallel banks");
    for (int w = 1; w >= 0; w--) begin
      for (int c = 0; c < N_INIT; c++) begin
        set_req(c, w[0], make_addr(c, 80), $random(seed));
      end
      run_round(4'hf, 1'b0, 1'b1);
    end
    wait_reads();
    end_test();

    begin_test("single bit correction");
    set_req(0, 1'b1, make_addr(2, 100), $random(seed));
    run_round(4'h1, 1'b0, 1'b0);
    reg_access(1'b0, REG_CORR_CNT, cnt_a);
    i_bank_model.flip_bits(2, 100, 39'h80);                       // Hamming position 7
    set_req(0, 1'b0, make_addr(2, 100), '0);
    run_round(4'h1, 1'b0, 1'b0);
    wait_reads();
    reg_access(1'b0, REG_CORR_CNT, cnt_b);
    check_equal("corrected count", 32'(cnt_a) + 1, 32'(cnt_b));
    end_test();

    begin_test("double bit detection");
    set_req(1, 1'b1, make_addr(3, 101), $random(seed));
    run_round(4'h2, 1'b0, 1'b0);
    reg_access(1'b0, REG_UNCORR_CNT, cnt_a);
    i_bank_model.flip_bits(3, 101, (39'h1 << 3) | (39'h1 << 20));
    reg_access(1'b0, REG_CORR_CNT, cnt_b);
    expect_multi = 1'b1;
    set_req(1, 1'b0, make_addr(3, 101), '0);
    run_round(4'h2, 1'b0, 1'b0);
    wait_reads();
    expect_multi = 1'b0;
    reg_access(1'b0, REG_UNCORR_CNT, cnt_c);
    check_equal("uncorrectable count", 32'(cnt_a) + 1, 32'(cnt_c));
    reg_access(1'b0, REG_CORR_CNT, cnt_c);
    check_equal("corrected count", 32'(cnt_b), 32'(cnt_c));
    end_test();

    begin_test("counter clear");
    reg_access(1'b1, REG_CORR_CNT, cnt_a);
    check_equal("clear response", 32'h0, 32'(cnt_a));
    reg_access(1'b1, REG_UNCORR_CNT, cnt_a);
    check_equal("clear response", 32'h0, 32'(cnt_a));
    for (int w = 1; w >= 0; w--) begin
      for (int c = 0; c < N_INIT; c++) begin
        set_req(c, w[0], addr_log[c], $random(seed));
      end
      run_round(4'hf, 1'b0, 1'b0);
    end
    wait_reads();
    reg_access(1'b0, REG_CORR_CNT, cnt_a);
    check_equal("corrected count", 32'h0, 32'(cnt_a));
    reg_access(1'b0, REG_UNCORR_CNT, cnt_a);
    check_equal("uncorrectable count", 32'h0, 32'(cnt_a));
    end_test();

    $display("Tests run %0d, tests failed %0d, failed checks %0d", test_cnt, test_fail, err_cnt);
    if (err_cnt == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: source/bank_request_arbiter.sv
// Bank decode and per-bank round-robin arbitration of core requests
`default_nettype none

module bank_request_arbiter (
  input  logic                                                          clk_i,
  input  logic                                                          rst_ni,
  input  ecc_xbar_pkg::core_req_t [ecc_xbar_pkg::N_INIT-1:0]            core_req_i,
  input  logic [ecc_xbar_pkg::N_INIT-1:0][ecc_xbar_pkg::CODE_W-1:0]     wcode_i,
  output logic [ecc_xbar_pkg::N_INIT-1:0]                               gnt_o,
  output ecc_xbar_pkg::bank_req_t [ecc_xbar_pkg::N_BANK-1:0]            bank_req_o,
  output logic [ecc_xbar_pkg::N_BANK-1:0][ecc_xbar_pkg::INIT_SEL_W-1:0] owner_o
);
  import ecc_xbar_pkg::*;

  logic [N_BANK-1:0][N_INIT-1:0]     req_mtx;                     // Core targets bank
  logic [N_BANK-1:0][N_INIT-1:0]     gnt_mtx;                     // Winner per bank
  logic [N_INIT-1:0][N_BANK-1:0]     gnt_col;                     // Same grants seen per core
  logic [N_BANK-1:0][INIT_SEL_W-1:0] rr_q;                        // First core to look at
  logic [N_BANK-1:0]                 hit;                         // Bank has a winner

  always_comb begin : proc_decode
    for (int b = 0; b < N_BANK; b++) begin
      for (int c = 0; c < N_INIT; c++) begin
        req_mtx[b][c] = core_req_i[c].req &&
                        (core_req_i[c].addr[ROW_LSB-1:BANK_LSB] == BANK_SEL_W'(b));
      end
    end
  end

  // Scan from the pointer and keep the first requester
  always_comb begin : proc_pick
    logic [INIT_SEL_W-1:0] cand;
    hit     = '0;
    gnt_mtx = '0;
    owner_o = rr_q;                                               // Idle banks park on pointer
    for (int b = 0; b < N_BANK; b++) begin
      for (int k = 0; k < N_INIT; k++) begin
        cand = rr_q[b] + INIT_SEL_W'(k);                          // Wraps modulo N_INIT
        if (!hit[b] && req_mtx[b][cand]) begin
          hit[b]           = 1'b1;
          owner_o[b]       = cand;
          gnt_mtx[b][cand] = 1'b1;
        end
      end
    end
  end

  always_comb begin : proc_gnt
    for (int c = 0; c < N_INIT; c++) begin
      for (int b = 0; b < N_BANK; b++) begin
        gnt_col[c][b] = gnt_mtx[b][c];
      end
      gnt_o[c] = |gnt_col[c];                                     // Granted by its bank
    end
  end

  always_comb begin : proc_bank_req
    for (int b = 0; b < N_BANK; b++) begin
      bank_req_o[b].req   = hit[b];
      bank_req_o[b].we    = core_req_i[owner_o[b]].we;
      bank_req_o[b].row   = core_req_i[owner_o[b]].addr[ADDR_W-1:ROW_LSB];
      bank_req_o[b].wcode = wcode_i[owner_o[b]];                  // Encoded in front of us
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : proc_rr
    if (!rst_ni) begin
      rr_q <= '0;                                                 // Core 0 first
    end else begin
      for (int b = 0; b < N_BANK; b++) begin
        if (hit[b]) begin
          rr_q[b] <= owner_o[b] + 1'b1;                           // Winner drops to last
        end
      end
    end
  end

  for (genvar b = 0; b < N_BANK; b++) begin : gen_bank_chk
    a_one_per_bank: assert property (@(posedge clk_i) disable iff (!rst_ni)
      $onehot0(gnt_mtx[b]));
  end

  for (genvar c = 0; c < N_INIT; c++) begin : gen_core_chk
    a_one_per_core: assert property (@(posedge clk_i) disable iff (!rst_ni)
      $onehot0(gnt_col[c]));
  end

endmodule

`default_nettype wire

// File: source/ecc_error_counters.sv
// Saturating ECC error counters with a read and clear register port
`default_nettype none

module ecc_error_counters (
  input  logic                                                clk_i,
  input  logic                                                rst_ni,
  input  ecc_xbar_pkg::ecc_event_t [ecc_xbar_pkg::N_BANK-1:0] read_event_i,
  input  ecc_xbar_pkg::reg_req_t                              reg_req_i,
  output ecc_xbar_pkg::reg_rsp_t                              reg_rsp_o
);
  import ecc_xbar_pkg::*;

  logic [N_CNT-1:0][CNT_W-1:0] cnt_q;                             // Indexed by opcode
  logic [N_CNT-1:0][CNT_W-1:0] inc;                               // Events this cycle
  logic [N_CNT-1:0][CNT_W:0]   sum;                               // Carry flags saturation
  logic [N_CNT-1:0]            clr;                               // Clear strobe per counter
  logic                        rsp_valid_q;
  logic [CNT_W-1:0]            rsp_rdata_q;

  always_comb begin : proc_tally
    inc = '0;
    for (int b = 0; b < N_BANK; b++) begin
      inc[REG_CORR_CNT]   += CNT_W'(read_event_i[b].single);
      inc[REG_UNCORR_CNT] += CNT_W'(read_event_i[b].multi);
    end
    for (int i = 0; i < N_CNT; i++) begin
      sum[i] = {1'b0, cnt_q[i]} + {1'b0, inc[i]};
      clr[i] = reg_req_i.valid && reg_req_i.we && (reg_req_i.op == ecc_reg_e'(i));
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : proc_cnt
    if (!rst_ni) begin
      cnt_q <= '0;
    end else begin
      for (int i = 0; i < N_CNT; i++) begin
        if (clr[i]) begin
          cnt_q[i] <= '0;                                         // Wins over new events
        end else if (sum[i][CNT_W]) begin
          cnt_q[i] <= '1;                                         // Stick at max
        end else begin
          cnt_q[i] <= sum[i][CNT_W-1:0];
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : proc_rsp_valid
    if (!rst_ni) begin
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_valid_q <= reg_req_i.valid;                             // Fixed one-cycle answer
    end
  end

  always_ff @(posedge clk_i) begin : proc_rsp_data
    if (reg_req_i.valid) begin
      rsp_rdata_q <= reg_req_i.we ? '0 : cnt_q[reg_req_i.op];     // Clear answers zero
    end
  end

  assign reg_rsp_o = '{valid: rsp_valid_q, rdata: rsp_rdata_q};

  for (genvar i = 0; i < N_CNT; i++) begin : gen_sat_chk
    a_no_wrap: assert property (@(posedge clk_i) disable iff (!rst_ni)
      ((cnt_q[i] == '1) && !clr[i]) |=> (cnt_q[i] == '1));
  end

endmodule

`default_nettype wire

// File: source/ecc_interconnect_top.sv
// Top level of the ECC multi-bank interconnect with codecs, router and counters
`default_nettype none

module ecc_interconnect_top (
  input  logic                                                      clk_i,
  input  logic                                                      rst_ni,
  input  ecc_xbar_pkg::core_req_t [ecc_xbar_pkg::N_INIT-1:0]        core_req_i,
  output ecc_xbar_pkg::core_rsp_t [ecc_xbar_pkg::N_INIT-1:0]        core_rsp_o,
  output ecc_xbar_pkg::bank_req_t [ecc_xbar_pkg::N_BANK-1:0]        bank_req_o,
  input  logic [ecc_xbar_pkg::N_BANK-1:0][ecc_xbar_pkg::CODE_W-1:0] bank_rcode_i,
  input  ecc_xbar_pkg::reg_req_t                                    reg_req_i,
  output ecc_xbar_pkg::reg_rsp_t                                    reg_rsp_o
);
  import ecc_xbar_pkg::*;

  logic [N_INIT-1:0][CODE_W-1:0]     wcode;                       // Encoded write data per core
  logic [N_INIT-1:0]                 gnt;
  logic [N_BANK-1:0][INIT_SEL_W-1:0] owner;                       // Winner per bank
  logic [N_BANK-1:0][DATA_W-1:0]     rdata;                       // Corrected bank words
  ecc_event_t [N_BANK-1:0]           dec_event;                   // Raw decoder flags
  ecc_event_t [N_BANK-1:0]           rd_event;                    // Flags on real reads only
  core_rsp_t [N_INIT-1:0]            rtr_rsp;                     // Response without gnt

  for (genvar c = 0; c < N_INIT; c++) begin : gen_enc
    secded_encoder i_secded_encoder (
      .data_i ( core_req_i[c].wdata ),
      .code_o ( wcode[c]            )
    );
  end

  bank_request_arbiter i_bank_request_arbiter (
    .clk_i      ( clk_i      ),
    .rst_ni     ( rst_ni     ),
    .core_req_i ( core_req_i ),
    .wcode_i    ( wcode      ),
    .gnt_o      ( gnt        ),
    .bank_req_o ( bank_req_o ),
    .owner_o    ( owner      )
  );

  for (genvar b = 0; b < N_BANK; b++) begin : gen_dec
    secded_decoder i_secded_decoder (
      .code_i  ( bank_rcode_i[b] ),
      .data_o  ( rdata[b]        ),
      .event_o ( dec_event[b]    )
    );
  end

  response_router i_response_router (
    .clk_i        ( clk_i      ),
    .rst_ni       ( rst_ni     ),
    .bank_req_i   ( bank_req_o ),
    .owner_i      ( owner      ),
    .bank_data_i  ( rdata      ),
    .bank_event_i ( dec_event  ),
    .core_rsp_o   ( rtr_rsp    ),
    .read_event_o ( rd_event   )
  );

  ecc_error_counters i_ecc_error_counters (
    .clk_i        ( clk_i     ),
    .rst_ni       ( rst_ni    ),
    .read_event_i ( rd_event  ),
    .reg_req_i    ( reg_req_i ),
    .reg_rsp_o    ( reg_rsp_o )
  );

  for (genvar c = 0; c < N_INIT; c++) begin : gen_rsp
    assign core_rsp_o[c] = '{gnt:     gnt[c],
                             r_valid: rtr_rsp[c].r_valid,
                             r_data:  rtr_rsp[c].r_data,
                             r_err:   rtr_rsp[c].r_err};
  end

endmodule

`default_nettype wire

// File: source/ecc_xbar_pkg.sv
// Interconnect sizes, address split, port structs and register opcodes
`default_nettype none

package ecc_xbar_pkg;

  localparam int unsigned N_INIT     = 4;                         // Core initiators
  localparam int unsigned N_BANK     = 4;                         // Word-interleaved banks
  localparam int unsigned BANK_SEL_W = 2;                         // Bank index bits
  localparam int unsigned INIT_SEL_W = 2;                         // Core index bits
  localparam int unsigned DATA_W     = 32;                        // Payload word
  localparam int unsigned PAR_W      = 7;                         // Six Hamming bits plus overall
  localparam int unsigned CODE_W     = DATA_W + PAR_W;            // Stored codeword
  localparam int unsigned ADDR_W     = 16;                        // Core byte address
  localparam int unsigned BANK_LSB   = 2;                         // Bank field starts above byte offset
  localparam int unsigned ROW_LSB    = BANK_LSB + BANK_SEL_W;     // Row field starts above bank field
  localparam int unsigned ROW_W      = ADDR_W - BANK_SEL_W - BANK_LSB;
  localparam int unsigned CNT_W      = 16;                        // Error counter width
  localparam int unsigned N_CNT      = 2;                         // Correctable and uncorrectable

  // Opcode value doubles as counter index
  typedef enum logic {
    REG_CORR_CNT   = 1'b0,                                        // Single-bit corrected
    REG_UNCORR_CNT = 1'b1                                         // Double-bit detected
  } ecc_reg_e;

  typedef struct packed {
    logic              req;                                       // Held until gnt
    logic              we;                                        // Low for read
    logic [ADDR_W-1:0] addr;                                      // Byte address
    logic [DATA_W-1:0] wdata;                                     // Full word only
  } core_req_t;

  typedef struct packed {
    logic              gnt;                                       // Same cycle as winning req
    logic              r_valid;                                   // One cycle after read gnt
    logic [DATA_W-1:0] r_data;                                    // Corrected read word
    logic              r_err;                                     // Uncorrectable read
  } core_rsp_t;

  typedef struct packed {
    logic              req;                                       // Bank access this cycle
    logic              we;                                        // Write codeword
    logic [ROW_W-1:0]  row;                                       // Word row inside bank
    logic [CODE_W-1:0] wcode;                                     // Encoded write word
  } bank_req_t;

  typedef struct packed {
    logic single;                                                 // Corrected one bit
    logic multi;                                                  // Detected two bits
  } ecc_event_t;

  typedef struct packed {
    logic     valid;                                              // One-cycle strobe
    logic     we;                                                 // Write clears counter
    ecc_reg_e op;                                                 // Counter select
  } reg_req_t;

  typedef struct packed {
    logic             valid;                                      // One cycle after strobe
    logic [CNT_W-1:0] rdata;                                      // Count or zero on clear
  } reg_rsp_t;

endpackage

`default_nettype wire

// File: source/response_router.sv
// Read response steering from banks back to the granted cores
`default_nettype none

module response_router (
  input  logic                                                          clk_i,
  input  logic                                                          rst_ni,
  input  ecc_xbar_pkg::bank_req_t [ecc_xbar_pkg::N_BANK-1:0]            bank_req_i,
  input  logic [ecc_xbar_pkg::N_BANK-1:0][ecc_xbar_pkg::INIT_SEL_W-1:0] owner_i,
  input  logic [ecc_xbar_pkg::N_BANK-1:0][ecc_xbar_pkg::DATA_W-1:0]     bank_data_i,
  input  ecc_xbar_pkg::ecc_event_t [ecc_xbar_pkg::N_BANK-1:0]           bank_event_i,
  output ecc_xbar_pkg::core_rsp_t [ecc_xbar_pkg::N_INIT-1:0]            core_rsp_o,
  output ecc_xbar_pkg::ecc_event_t [ecc_xbar_pkg::N_BANK-1:0]           read_event_o
);
  import ecc_xbar_pkg::*;

  logic [N_BANK-1:0]                 rd_q;                        // Read issued last cycle
  logic [N_BANK-1:0][INIT_SEL_W-1:0] own_q;                       // Core that issued it

  always_ff @(posedge clk_i or negedge rst_ni) begin : proc_track
    if (!rst_ni) begin
      rd_q  <= '0;
      own_q <= '0;
    end else begin
      for (int b = 0; b < N_BANK; b++) begin
        rd_q[b] <= bank_req_i[b].req && !bank_req_i[b].we;
      end
      own_q <= owner_i;
    end
  end

  always_comb begin : proc_steer
    core_rsp_o   = '0;                                            // Gnt field merged at top
    read_event_o = '0;
    for (int b = 0; b < N_BANK; b++) begin
      if (rd_q[b]) begin
        read_event_o[b]             = bank_event_i[b];            // Stale codes not counted
        core_rsp_o[own_q[b]].r_valid = 1'b1;
        core_rsp_o[own_q[b]].r_data  = bank_data_i[b];
        core_rsp_o[own_q[b]].r_err   = bank_event_i[b].multi;     // Only uncorrectable flagged
      end
    end
  end

endmodule

`default_nettype wire

// File: source/secded_decoder.sv
// SECDED Hamming decoder with single-bit correction and double-bit detection
`default_nettype none

module secded_decoder (
  input  logic [ecc_xbar_pkg::CODE_W-1:0] code_i,
  output logic [ecc_xbar_pkg::DATA_W-1:0] data_o,
  output ecc_xbar_pkg::ecc_event_t        event_o
);
  import ecc_xbar_pkg::*;

  always_comb begin : proc_decode
    logic [CODE_W-1:0]  c;
    logic [PAR_W-2:0]   syn;
    logic               odd;
    int unsigned        d;
    c   = code_i;
    syn = '0;
    for (int unsigned k = 0; k < PAR_W - 1; k++) begin
      for (int unsigned p = 1; p < CODE_W; p++) begin
        if (((p >> k) & 1) != 0) begin
          syn[k] ^= c[p];                                         // Includes parity slot
        end
      end
    end
    odd     = ^c;                                                 // Overall parity check
    event_o = '0;
    if (syn != '0) begin
      if (odd && (syn < CODE_W)) begin
        c[syn]         = ~c[syn];                                 // Syndrome names the bad bit
        event_o.single = 1'b1;
      end else begin
        event_o.multi = 1'b1;                                     // Even parity or off the end
      end
    end else if (odd) begin
      // Only the overall parity bit flipped, payload intact
      event_o.single = 1'b1;
    end
    data_o = '0;
    d      = 0;
    for (int unsigned p = 1; p < CODE_W; p++) begin
      if ((p & (p - 1)) != 0) begin                               // Skip parity slots
        data_o[d] = c[p];
        d++;
      end
    end
  end

endmodule

`default_nettype wire

// File: source/secded_encoder.sv
// SECDED Hamming encoder from a 32-bit word to a 39-bit codeword
`default_nettype none

module secded_encoder (
  input  logic [ecc_xbar_pkg::DATA_W-1:0] data_i,
  output logic [ecc_xbar_pkg::CODE_W-1:0] code_o
);
  import ecc_xbar_pkg::*;

  // Bit 0 holds overall parity, bits 1 to 38 are Hamming positions
  always_comb begin : proc_encode
    logic [CODE_W-1:0] c;
    int unsigned       d;
    c = '0;
    d = 0;
    for (int unsigned p = 1; p < CODE_W; p++) begin
      if ((p & (p - 1)) != 0) begin                               // Not a parity slot
        c[p] = data_i[d];
        d++;
      end
    end
    for (int unsigned k = 0; k < PAR_W - 1; k++) begin
      for (int unsigned p = 1; p < CODE_W; p++) begin
        if ((((p >> k) & 1) != 0) && ((p & (p - 1)) != 0)) begin
          c[1 << k] ^= c[p];                                      // Parity at 1,2,4,8,16,32
        end
      end
    end
    c[0]   = ^c[CODE_W-1:1];                                      // Makes whole word even
    code_o = c;
  end

endmodule

`default_nettype wire
